//--- rtl/core_params.svh
/*
 * Core-wide sizes: data width, register file geometry
 * and the credit depths of the input and retire ports
 */

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and register file
`define XLEN        32
`define NREGS       32
`define RADDR_W     5

// Input FIFO depth, also the credits the source starts with
`define IN_CREDITS  4
// Sink buffer depth, credits held by the execute stage after reset
`define OUT_CREDITS 2

`endif

//--- rtl/isa_pkg.sv
/*
 * RV32I encodings for the supported integer subset:
 * opcodes, funct codes, R/I instruction views and the instruction union
 */

package isa_pkg;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // funct3 field
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 field, ALT selects SUB and SRA
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Same 32-bit word, seen raw or through either format
  typedef union packed {
    logic [31:0] raw;
    r_fmt_t      r;
    i_fmt_t      i;
  } instr_u;

endpackage

//--- rtl/pipe_pkg.sv
/*
 * Pipeline types: ALU operation encoding,
 * decode-to-execute payload and the retire record
 */

`include "core_params.svh"

package pipe_pkg;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
  } alu_op_e;

  // Decode to execute
  typedef struct packed {
    alu_op_e             alu_op;
    logic [`XLEN-1:0]    operand_a;
    logic [`XLEN-1:0]    operand_b;
    logic [`RADDR_W-1:0] rd;
    logic                we;
    logic                illegal;
  } id_ex_t;

  // Retire port record, also used for forwarding
  typedef struct packed {
    logic [`RADDR_W-1:0] rd;
    logic [`XLEN-1:0]    result;
    logic                we;
    logic                illegal;
  } retire_t;

endpackage

//--- rtl/reg_file.sv
/*
 * Integer register file, two combinational read ports
 * and one write port, x0 hardwired to zero
 */

`timescale 1ns/1ns
`include "core_params.svh"

module reg_file (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`RADDR_W-1:0] raddr_a_i,
  input  logic [`RADDR_W-1:0] raddr_b_i,
  output logic [`XLEN-1:0]    rdata_a_o,
  output logic [`XLEN-1:0]    rdata_b_o,
  input  logic                we_i,
  input  logic [`RADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]    wdata_i
);

  logic [`XLEN-1:0] regs_q [`NREGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- rtl/decode_stage.sv
/*
 * Decode stage: credit-managed input FIFO, instruction decode,
 * immediate generation, operand read with forwarding, ID/EX register
 */

`timescale 1ns/1ns
`include "core_params.svh"

module decode_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_valid_i,
  input  isa_pkg::instr_u     instr_i,
  output logic                instr_credit_o,
  output logic [`RADDR_W-1:0] raddr_a_o,
  output logic [`RADDR_W-1:0] raddr_b_o,
  input  logic [`XLEN-1:0]    rdata_a_i,
  input  logic [`XLEN-1:0]    rdata_b_i,
  input  logic                fwd_valid_i,
  input  pipe_pkg::retire_t   fwd_i,
  input  logic                ex_ready_i,
  output logic                id_ex_valid_o,
  output pipe_pkg::id_ex_t    id_ex_o
);

  localparam int unsigned PTR_W = $clog2(`IN_CREDITS);
  localparam int unsigned CNT_W = $clog2(`IN_CREDITS + 1);

  isa_pkg::instr_u   fifo_q [`IN_CREDITS];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              pop;
  logic              credit_q;
  isa_pkg::instr_u   head;
  logic              is_op;
  logic              alt;
  logic              shift_f3;
  logic              funct7_ok;
  logic [`XLEN-1:0]  imm_i;
  logic [`XLEN-1:0]  imm_sh;
  logic [`XLEN-1:0]  imm_u;
  logic [`XLEN-1:0]  rs1_val;
  logic [`XLEN-1:0]  rs2_val;
  pipe_pkg::id_ex_t  id_ex_d;
  logic              id_ex_valid_q;
  pipe_pkg::id_ex_t  id_ex_q;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(`IN_CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Input FIFO
  //////////////////////////////////////////////////////////////////////

  // Source never sends without a credit, so a push never meets a full FIFO
  assign pop  = (count_q != '0) && ex_ready_i;
  assign head = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      fifo_q[wr_ptr_q] <= instr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (instr_valid_i) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      count_q  <= count_q + CNT_W'(instr_valid_i) - CNT_W'(pop);
      // One credit back per popped entry
      credit_q <= pop;
    end
  end

  assign instr_credit_o = credit_q;

  //////////////////////////////////////////////////////////////////////
  // Decode and operands
  //////////////////////////////////////////////////////////////////////

  assign raddr_a_o = head.r.rs1;
  assign raddr_b_o = head.r.rs2;

  // Bypass from the instruction currently in execute
  assign rs1_val = (fwd_valid_i && fwd_i.we && (fwd_i.rd != '0) && (fwd_i.rd == raddr_a_o)) ?
                   fwd_i.result : rdata_a_i;
  assign rs2_val = (fwd_valid_i && fwd_i.we && (fwd_i.rd != '0) && (fwd_i.rd == raddr_b_o)) ?
                   fwd_i.result : rdata_b_i;

  assign imm_i  = {{(`XLEN-12){head.i.imm12[11]}}, head.i.imm12};
  assign imm_sh = {{(`XLEN-5){1'b0}}, head.r.rs2};
  assign imm_u  = {head.raw[31:12], 12'b0};

  assign is_op     = head.r.opcode == isa_pkg::OPC_OP;
  assign alt       = head.r.funct7 == isa_pkg::F7_ALT;
  assign shift_f3  = (head.r.funct3 == isa_pkg::F3_SLL) ||
                     (head.r.funct3 == isa_pkg::F3_SRL_SRA);
  // ALT only legal on SRA/SRAI and SUB
  assign funct7_ok = (head.r.funct7 == isa_pkg::F7_BASE) ||
                     (alt && ((head.r.funct3 == isa_pkg::F3_SRL_SRA) ||
                              (is_op && (head.r.funct3 == isa_pkg::F3_ADD_SUB))));

  always_comb begin
    id_ex_d.alu_op    = pipe_pkg::ALU_ADD;
    id_ex_d.operand_a = rs1_val;
    id_ex_d.operand_b = rs2_val;
    id_ex_d.rd        = head.r.rd;
    id_ex_d.illegal   = 1'b0;
    case (head.r.funct3)
      isa_pkg::F3_ADD_SUB: id_ex_d.alu_op = (is_op && alt) ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
      isa_pkg::F3_SLL:     id_ex_d.alu_op = pipe_pkg::ALU_SLL;
      isa_pkg::F3_SLT:     id_ex_d.alu_op = pipe_pkg::ALU_SLT;
      isa_pkg::F3_SLTU:    id_ex_d.alu_op = pipe_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:     id_ex_d.alu_op = pipe_pkg::ALU_XOR;
      isa_pkg::F3_SRL_SRA: id_ex_d.alu_op = alt ? pipe_pkg::ALU_SRA : pipe_pkg::ALU_SRL;
      isa_pkg::F3_OR:      id_ex_d.alu_op = pipe_pkg::ALU_OR;
      default:             id_ex_d.alu_op = pipe_pkg::ALU_AND;
    endcase
    case (head.r.opcode)
      isa_pkg::OPC_OP: id_ex_d.illegal = !funct7_ok;
      isa_pkg::OPC_OP_IMM: begin
        id_ex_d.illegal   = shift_f3 && !funct7_ok;
        id_ex_d.operand_b = shift_f3 ? imm_sh : imm_i;
      end
      isa_pkg::OPC_LUI: begin
        // 0 + U immediate
        id_ex_d.alu_op    = pipe_pkg::ALU_ADD;
        id_ex_d.operand_a = '0;
        id_ex_d.operand_b = imm_u;
      end
      default: id_ex_d.illegal = 1'b1;
    endcase
    id_ex_d.we = !id_ex_d.illegal;
  end

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_ex_valid_q <= 1'b0;
    end else if (pop) begin
      id_ex_valid_q <= 1'b1;
    end else if (ex_ready_i) begin
      id_ex_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) id_ex_q <= id_ex_d;
  end

  assign id_ex_valid_o = id_ex_valid_q;
  assign id_ex_o       = id_ex_q;

endmodule

//--- rtl/exec_stage.sv
/*
 * Execute stage: ALU, retire credit counter,
 * retire register and register file write-back
 */

`timescale 1ns/1ns
`include "core_params.svh"

module exec_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                id_ex_valid_i,
  input  pipe_pkg::id_ex_t    id_ex_i,
  output logic                ex_ready_o,
  output logic                fwd_valid_o,
  output pipe_pkg::retire_t   fwd_o,
  output logic                rf_we_o,
  output logic [`RADDR_W-1:0] rf_waddr_o,
  output logic [`XLEN-1:0]    rf_wdata_o,
  input  logic                ret_credit_i,
  output logic                retire_valid_o,
  output pipe_pkg::retire_t   retire_o
);

  localparam int unsigned CRD_W   = $clog2(`OUT_CREDITS + 1);
  localparam int unsigned SHAMT_W = $clog2(`XLEN);

  logic [CRD_W-1:0]   credits_q;
  logic               fire;
  logic [`XLEN-1:0]   op_a;
  logic [`XLEN-1:0]   op_b;
  logic [SHAMT_W-1:0] shamt;
  logic [`XLEN-1:0]   result;
  pipe_pkg::retire_t  cur;
  logic               retire_valid_q;
  pipe_pkg::retire_t  retire_q;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  assign op_a  = id_ex_i.operand_a;
  assign op_b  = id_ex_i.operand_b;
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (id_ex_i.alu_op)
      pipe_pkg::ALU_ADD:  result = op_a + op_b;
      pipe_pkg::ALU_SUB:  result = op_a - op_b;
      pipe_pkg::ALU_SLL:  result = op_a << shamt;
      pipe_pkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      pipe_pkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, op_a < op_b};
      pipe_pkg::ALU_XOR:  result = op_a ^ op_b;
      pipe_pkg::ALU_SRL:  result = op_a >> shamt;
      pipe_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
      pipe_pkg::ALU_OR:   result = op_a | op_b;
      default:            result = op_a & op_b;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Credits, retire and write-back
  //////////////////////////////////////////////////////////////////////

  // Retire only while the sink has room
  assign fire       = id_ex_valid_i && (credits_q != '0);
  assign ex_ready_o = !id_ex_valid_i || fire;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q      <= CRD_W'(`OUT_CREDITS);
      retire_valid_q <= 1'b0;
    end else begin
      credits_q      <= credits_q - CRD_W'(fire) + CRD_W'(ret_credit_i);
      retire_valid_q <= fire;
    end
  end

  always_comb begin
    cur.rd      = id_ex_i.rd;
    cur.result  = result;
    cur.we      = id_ex_i.we;
    cur.illegal = id_ex_i.illegal;
  end

  always_ff @(posedge clk_i) begin
    if (fire) retire_q <= cur;
  end

  assign fwd_valid_o    = id_ex_valid_i;
  assign fwd_o          = cur;
  assign rf_we_o        = fire && id_ex_i.we;
  assign rf_waddr_o     = id_ex_i.rd;
  assign rf_wdata_o     = result;
  assign retire_valid_o = retire_valid_q;
  assign retire_o       = retire_q;

endmodule

//--- rtl/int_core.sv
/*
 * Integer core top: decode stage, execute stage and register file
 */

`timescale 1ns/1ns
`include "core_params.svh"

module int_core (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_valid_i,
  input  isa_pkg::instr_u   instr_i,
  output logic              instr_credit_o,
  input  logic              ret_credit_i,
  output logic              retire_valid_o,
  output pipe_pkg::retire_t retire_o
);

  logic [`RADDR_W-1:0] raddr_a;
  logic [`RADDR_W-1:0] raddr_b;
  logic [`XLEN-1:0]    rdata_a;
  logic [`XLEN-1:0]    rdata_b;
  logic                fwd_valid;
  pipe_pkg::retire_t   fwd;
  logic                ex_ready;
  logic                id_ex_valid;
  pipe_pkg::id_ex_t    id_ex;
  logic                rf_we;
  logic [`RADDR_W-1:0] rf_waddr;
  logic [`XLEN-1:0]    rf_wdata;

  decode_stage u_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .raddr_a_o      (raddr_a),
    .raddr_b_o      (raddr_b),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .fwd_valid_i    (fwd_valid),
    .fwd_i          (fwd),
    .ex_ready_i     (ex_ready),
    .id_ex_valid_o  (id_ex_valid),
    .id_ex_o        (id_ex)
  );

  exec_stage u_exec (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .id_ex_valid_i  (id_ex_valid),
    .id_ex_i        (id_ex),
    .ex_ready_o     (ex_ready),
    .fwd_valid_o    (fwd_valid),
    .fwd_o          (fwd),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .ret_credit_i   (ret_credit_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  // Write port driven from execute
  reg_file u_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

endmodule

//--- sim/tb_int_core.sv
/*
 * Testbench for int_core with clock and reset, credit-tracked source and sink,
 * reference model of the ALU subset and an in-order retire checker
 */

`timescale 1ns/1ns
`include "core_params.svh"

module tb_int_core;

  localparam int N_IDLE     = 10;
  localparam int N_RAND     = 200;
  localparam int N_SHIFT    = 11;
  localparam int N_DEP      = 20;
  localparam int N_HOLD     = 8;
  localparam int N_ILL      = 8;
  localparam int MAX_CYCLES = 20 * (N_RAND + N_SHIFT + N_DEP + N_HOLD + N_ILL) + 200;
  localparam int SINK_NOW   = 0;
  localparam int SINK_RAND  = 1;
  localparam int SINK_HOLD  = 2;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              instr_valid_i;
  isa_pkg::instr_u   instr_i;
  logic              instr_credit_o;
  logic              ret_credit_i = 1'b0;
  logic              retire_valid_o;
  pipe_pkg::retire_t retire_o;

  integer            seed = 32'ha7f6_2841;
  logic [255:0]      sink_gaps;
  logic [7:0]        gap_idx = 8'd0;
  int                sink_mode = SINK_NOW;
  int                sent_count = 0;
  int                crd_returned = 0;
  int                credits_given = 0;
  int                retired = 0;
  int                check_idx = 0;
  int                check_errors = 0;
  int                flow_errors = 0;
  int                tests = 0;
  int                cycles = 0;
  logic [`XLEN-1:0]  ref_regs [`NREGS];
  pipe_pkg::retire_t exp_q [$];
  string             name_q [$];
  string             test_name;

  int_core dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .ret_credit_i   (ret_credit_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Encoders and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, isa_pkg::OPC_LUI};
  endfunction

  // RV32I result for one funct3 with alt selecting SUB or SRA
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic pipe_pkg::retire_t ref_exec(input logic [31:0] instr,
                                                 input logic [`XLEN-1:0] regs [`NREGS]);
    pipe_pkg::retire_t rec;
    logic [6:0]        f7;
    logic [2:0]        f3;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       imm;
    f7          = instr[31:25];
    f3          = instr[14:12];
    a           = regs[instr[19:15]];
    b           = regs[instr[24:20]];
    imm         = {{20{instr[31]}}, instr[31:20]};
    rec.rd      = instr[11:7];
    rec.result  = '0;
    rec.illegal = 1'b0;
    case (instr[6:0])
      isa_pkg::OPC_OP: begin
        rec.illegal = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101))));
        rec.result  = alu_ref(f3, instr[30], a, b);
      end
      isa_pkg::OPC_OP_IMM: begin
        if ((f3 == 3'b001) || (f3 == 3'b101)) begin
          rec.illegal = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b101)));
          rec.result  = alu_ref(f3, instr[30], a, {27'b0, instr[24:20]});
        end else begin
          rec.result  = alu_ref(f3, 1'b0, a, imm);
        end
      end
      isa_pkg::OPC_LUI: rec.result = {instr[31:12], 12'b0};
      default:          rec.illegal = 1'b1;
    endcase
    rec.we = !rec.illegal;
    return rec;
  endfunction

  function automatic int src_credits();
    return `IN_CREDITS + crd_returned - sent_count;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Source side
  //////////////////////////////////////////////////////////////////////

  // Called and returns at 2 ns after a rising edge
  task automatic send(input logic [31:0] w);
    pipe_pkg::retire_t rec;
    while (src_credits() == 0) begin
      @(posedge clk_i);
      #2;
    end
    rec = ref_exec(w, ref_regs);
    if (rec.we && (rec.rd != 5'd0)) ref_regs[rec.rd] = rec.result;
    exp_q.push_back(rec);
    name_q.push_back(test_name);
    instr_i       = w;
    instr_valid_i = 1'b1;
    sent_count++;
    @(posedge clk_i);
    #2;
    instr_valid_i = 1'b0;
  endtask

  task automatic rand_alu(output logic [31:0] w);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r  = $random(seed);
    f3 = r[2:0];
    f7 = (r[3] && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'h20 : 7'h00;
    if (r[4]) begin
      w = enc_r(f7, r[9:5], r[14:10], f3, r[19:15]);
    end else if ((f3 == 3'b001) || (f3 == 3'b101)) begin
      w = enc_i({f7, r[9:5]}, r[14:10], f3, r[19:15], isa_pkg::OPC_OP_IMM);
    end else begin
      w = enc_i(r[31:20], r[14:10], f3, r[19:15], isa_pkg::OPC_OP_IMM);
    end
  endtask

  task automatic idle_check(input int n);
    repeat (n) begin
      @(negedge clk_i);
      if ((retire_valid_o !== 1'b0) || (instr_credit_o !== 1'b0)) begin
        $display("ERROR retire or credit output active while the core is idle");
        flow_errors++;
      end
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic end_test(input int errs_before);
    while (check_idx != exp_q.size()) begin
      @(posedge clk_i);
      #2;
    end
    // Sink hands back its last credits
    while (credits_given != retired) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2;
    tests++;
    $display("test %s done: %0d errors", test_name, check_errors + flow_errors - errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sink, checker and watchdog
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    #2;
    if ((retired > credits_given) && ((sink_mode == SINK_NOW) ||
        ((sink_mode == SINK_RAND) && sink_gaps[gap_idx]))) begin
      ret_credit_i = 1'b1;
      credits_given++;
    end else begin
      ret_credit_i = 1'b0;
    end
    gap_idx++;
  end

  always @(negedge clk_i) begin
    pipe_pkg::retire_t want;
    if (rst_ni) begin
      if (instr_credit_o) crd_returned++;
      if (retire_valid_o) begin
        retired++;
        if (check_idx >= exp_q.size()) begin
          $display("ERROR retire seen with no instruction outstanding");
          check_errors++;
        end else begin
          want = exp_q[check_idx];
          if ((retire_o.rd !== want.rd) || (retire_o.we !== want.we) ||
              (retire_o.illegal !== want.illegal) ||
              (!want.illegal && (retire_o.result !== want.result))) begin
            $display("FAIL %s: expected rd=%0d result=%h we=%b illegal=%b, %s",
                     name_q[check_idx], want.rd, want.result, want.we, want.illegal,
                     $sformatf("actual rd=%0d result=%h we=%b illegal=%b",
                               retire_o.rd, retire_o.result, retire_o.we,
                               retire_o.illegal));
            check_errors++;
          end
          check_idx++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests did not complete within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          e0;
    int          r0;
    int          sent;
    logic [31:0] w;
    logic [4:0]  prev;
    logic [4:0]  rd;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    for (int i = 0; i < `NREGS; i++) ref_regs[i] = '0;
    for (int k = 0; k < 8; k++) sink_gaps[k*32 +: 32] = $random(seed);
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    test_name = "idle after reset";
    e0 = check_errors + flow_errors;
    idle_check(N_IDLE);
    end_test(e0);

    test_name = "random alu";
    e0 = check_errors + flow_errors;
    for (int i = 0; i < N_RAND; i++) begin
      rand_alu(w);
      send(w);
    end
    end_test(e0);

    // Writes to x0 followed by reads of x0
    test_name = "lui shift x0";
    e0 = check_errors + flow_errors;
    sink_mode = SINK_RAND;
    send(enc_u(20'habcde, 5'd5));
    send(enc_i(12'h003, 5'd5, 3'b001, 5'd6, isa_pkg::OPC_OP_IMM));
    send(enc_i(12'h007, 5'd5, 3'b101, 5'd7, isa_pkg::OPC_OP_IMM));
    send(enc_i(12'h40c, 5'd5, 3'b101, 5'd8, isa_pkg::OPC_OP_IMM));
    send(enc_i(12'h41f, 5'd5, 3'b101, 5'd9, isa_pkg::OPC_OP_IMM));
    send(enc_i(12'h000, 5'd5, 3'b001, 5'd10, isa_pkg::OPC_OP_IMM));
    send(enc_u(20'h12345, 5'd0));
    send(enc_i(12'd100, 5'd5, 3'b000, 5'd0, isa_pkg::OPC_OP_IMM));
    send(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd0));
    send(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd11));
    send(enc_r(7'h00, 5'd0, 5'd5, 3'b000, 5'd12));
    end_test(e0);

    test_name = "dependent chain";
    e0 = check_errors + flow_errors;
    sink_mode = SINK_NOW;
    prev = 5'd1;
    send(enc_i(12'd17, 5'd0, 3'b000, prev, isa_pkg::OPC_OP_IMM));
    for (int i = 1; i < N_DEP; i++) begin
      rand_alu(w);
      rd = w[11:7];
      if (rd == 5'd0) rd = 5'd20;
      w[19:15] = prev;
      if ((w[6:0] == isa_pkg::OPC_OP) && (i % 2 == 1)) w[24:20] = prev;
      w[11:7] = rd;
      send(w);
      prev = rd;
    end
    end_test(e0);

    test_name = "credit back-pressure";
    e0 = check_errors + flow_errors;
    sink_mode = SINK_HOLD;
    r0 = retired;
    sent = 0;
    repeat (30) begin
      if ((sent < N_HOLD) && (src_credits() > 0)) begin
        rand_alu(w);
        send(w);
        sent++;
      end else begin
        @(posedge clk_i);
        #2;
      end
    end
    if (retired - r0 > `OUT_CREDITS) begin
      $display("ERROR more retires than sink credits while credits were withheld");
      flow_errors++;
    end
    if (src_credits() != 0) begin
      $display("ERROR input credits did not drain while the sink was stalled");
      flow_errors++;
    end
    sink_mode = SINK_NOW;
    while (sent < N_HOLD) begin
      rand_alu(w);
      send(w);
      sent++;
    end
    end_test(e0);

    // Load, branch, JAL, fence, MUL and SLLI with funct7 set
    test_name = "illegal opcodes";
    e0 = check_errors + flow_errors;
    sink_mode = SINK_RAND;
    send(enc_i(12'h004, 5'd2, 3'b010, 5'd3, 7'b0000011));
    send({7'h00, 5'd1, 5'd2, 3'b000, 5'd4, 7'b1100011});
    send({20'h12345, 5'd3, 7'b1101111});
    send({20'h00000, 5'd4, 7'b0001111});
    send(enc_r(7'h01, 5'd5, 5'd6, 3'b000, 5'd3));
    send(enc_i({7'h20, 5'd3}, 5'd6, 3'b001, 5'd4, isa_pkg::OPC_OP_IMM));
    send(enc_r(7'h00, 5'd0, 5'd3, 3'b000, 5'd15));
    send(enc_r(7'h00, 5'd0, 5'd4, 3'b000, 5'd16));
    end_test(e0);

    if (src_credits() != `IN_CREDITS) begin
      $display("ERROR input credits not all returned at the end of the run");
      flow_errors++;
    end
    $display("summary: %0d tests, %0d retired, %0d errors",
             tests, retired, check_errors + flow_errors);
    if (check_errors + flow_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/exec_stage.sv
rtl/int_core.sv
sim/tb_int_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the int_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_int_core -o tb_int_core
out=$(./obj_dir/tb_int_core)
echo "$out"

if grep -qx "TEST PASS" <<< "$out"; then
  exit 0
fi
exit 1
